//--- source/tile_defs.svh
`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

// Flat execution trace, packed LSB first
`define TRACE_WBDATA_LSB   0        // Written register value
`define TRACE_WBDATA_MSB   31
`define TRACE_WBREG_LSB    32       // Destination register index
`define TRACE_WBREG_MSB    33
`define TRACE_WBEN_BIT     34       // Register file write enable
`define TRACE_INSN_LSB     35       // Retired instruction word
`define TRACE_INSN_MSB     66
`define TRACE_PC_LSB       67       // Retired instruction address
`define TRACE_PC_MSB       98
`define TRACE_VALID_BIT    99       // One pulse per retired instruction

// Valid bit is the topmost field
`define TRACE_WIDTH        (`TRACE_VALID_BIT + 1)

// Local data RAM depth as a word address width
`define LOCAL_RAM_AW       6

`endif

//--- source/isa_pkg.sv
package isa_pkg;

   localparam int WORD_W = 32;            // Data path width
   localparam int OPC_W  = 4;             // Opcode field
   localparam int REG_W  = 2;             // Register index field
   localparam int IMM_W  = 16;            // Immediate field

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_W-1:0]  reg_idx_t;  // Four general registers
   typedef logic [IMM_W-1:0]  imm_t;

   typedef enum logic [OPC_W-1:0] {
      OP_NOP  = 4'd0,
      OP_LI   = 4'd1,                     // rd = sext(imm)
      OP_ADDI = 4'd2,                     // rd = rd + sext(imm)
      OP_ADD  = 4'd3,                     // rd = rd + rs
      OP_LW   = 4'd4,                     // rd = mem[rs + sext(imm)]
      OP_SW   = 4'd5,                     // mem[rs + sext(imm)] = rd
      OP_BNZ  = 4'd6,                     // if (rd != 0) pc = imm * 4
      OP_HALT = 4'd7
   } opcode_e;

   // Instruction word layout, bits 31 down to 0
   typedef struct packed {
      logic [OPC_W-1:0] opcode;           // Bits 31..28
      reg_idx_t         rd;               // Bits 27..26
      reg_idx_t         rs;               // Bits 25..24
      logic [7:0]       rsvd;             // Bits 23..16, ignored
      imm_t             imm;              // Bits 15..0
   } insn_t;

   // Upper half of the opcode space executes as a no-op
   function automatic opcode_e decode_op(logic [OPC_W-1:0] raw);
      return raw[OPC_W-1] ? OP_NOP : opcode_e'(raw);
   endfunction

endpackage

//--- source/bus_pkg.sv
package bus_pkg;

   // Wishbone B3 cycle type identifier
   typedef enum logic [2:0] {
      CTI_CLASSIC = 3'b000,               // Single classic transfer
      CTI_END     = 3'b111                // Burst end, reserved here
   } wb_cti_e;

   // Core control sequencing
   typedef enum logic [1:0] {
      ST_FETCH = 2'd0,                    // Instruction bus access
      ST_EXEC  = 2'd1,                    // Decode, execute, most retire here
      ST_DATA  = 2'd2,                    // Data bus access for LW and SW
      ST_HALT  = 2'd3                     // Parked after HALT
   } core_state_e;

endpackage

//--- source/cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
   input  logic                clk_i,
   input  logic                arst_n_i,

   // Instruction Wishbone master
   output logic                iwbm_cyc_o,
   output logic                iwbm_stb_o,
   output isa_pkg::word_t      iwbm_adr_o,
   output bus_pkg::wb_cti_e    iwbm_cti_o,
   input  logic                iwbm_ack_i,
   input  isa_pkg::word_t      iwbm_dat_i,

   // Data Wishbone master
   output logic                dwbm_cyc_o,
   output logic                dwbm_stb_o,
   output logic                dwbm_we_o,
   output isa_pkg::word_t      dwbm_adr_o,
   output isa_pkg::word_t      dwbm_dat_o,
   output bus_pkg::wb_cti_e    dwbm_cti_o,
   input  logic                dwbm_ack_i,
   input  isa_pkg::word_t      dwbm_dat_i,

   // Debug unit
   input  logic                du_stall_i,     // Holds off new fetches
   output logic                du_halt_o,      // High once HALT retired

   // Execution trace
   output logic                traceport_exec_valid_o,
   output isa_pkg::word_t      traceport_exec_pc_o,
   output isa_pkg::word_t      traceport_exec_insn_o,
   output logic                traceport_exec_wben_o,
   output isa_pkg::reg_idx_t   traceport_exec_wbreg_o,
   output isa_pkg::word_t      traceport_exec_wbdata_o
);

   bus_pkg::core_state_e state_q;
   isa_pkg::word_t       pc_q;
   isa_pkg::insn_t       ir_q;                 // Instruction being executed
   isa_pkg::word_t       regs_q [4];
   logic                 iwb_stb_q;            // Fetch in flight
   logic                 dwb_stb_q;            // Data access in flight
   logic                 dwb_we_q;
   isa_pkg::word_t       dwb_adr_q;
   isa_pkg::word_t       dwb_dat_q;

   isa_pkg::opcode_e     op;
   isa_pkg::word_t       rd_val;
   isa_pkg::word_t       rs_val;
   isa_pkg::word_t       imm_sext;
   isa_pkg::word_t       wb_val;
   isa_pkg::word_t       pc_next;
   logic                 is_mem;
   logic                 fetch_done;
   logic                 dwb_done;
   logic                 retire;
   logic                 wben;

   // Decode
   assign op       = isa_pkg::decode_op(ir_q.opcode);
   assign rd_val   = regs_q[ir_q.rd];
   assign rs_val   = regs_q[ir_q.rs];
   assign imm_sext = {{16{ir_q.imm[15]}}, ir_q.imm};
   assign is_mem   = (op == isa_pkg::OP_LW) || (op == isa_pkg::OP_SW);

   assign fetch_done = (state_q == bus_pkg::ST_FETCH) && iwb_stb_q && iwbm_ack_i;
   assign dwb_done   = dwb_stb_q && dwbm_ack_i;

   // Memory ops retire on the data ack, everything else in ST_EXEC
   assign retire = ((state_q == bus_pkg::ST_EXEC) && !is_mem) ||
                   ((state_q == bus_pkg::ST_DATA) && dwb_done);

   assign wben = retire && (op inside {isa_pkg::OP_LI, isa_pkg::OP_ADDI,
                                       isa_pkg::OP_ADD, isa_pkg::OP_LW});

   // Writeback value
   always_comb begin
      case (op)
         isa_pkg::OP_LI:   wb_val = imm_sext;
         isa_pkg::OP_ADDI: wb_val = rd_val + imm_sext;
         isa_pkg::OP_ADD:  wb_val = rd_val + rs_val;
         isa_pkg::OP_LW:   wb_val = dwbm_dat_i;   // Load data arrives with ack
         default:          wb_val = '0;
      endcase
   end

   // Taken BNZ jumps to an absolute word index, zero extended
   always_comb begin
      if ((op == isa_pkg::OP_BNZ) && (rd_val != '0)) begin
         pc_next = {14'b0, ir_q.imm, 2'b00};
      end else begin
         pc_next = pc_q + 32'd4;
      end
   end

   // Control state, pc, register file
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= bus_pkg::ST_FETCH;
         pc_q      <= '0;
         iwb_stb_q <= 1'b0;
         dwb_stb_q <= 1'b0;
         dwb_we_q  <= 1'b0;
         for (int i = 0; i < 4; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         if (wben) begin
            regs_q[ir_q.rd] <= wb_val;
         end
         case (state_q)
            bus_pkg::ST_FETCH: begin
               if (iwb_stb_q) begin
                  if (iwbm_ack_i) begin            // Strobe held until ack
                     iwb_stb_q <= 1'b0;
                     state_q   <= bus_pkg::ST_EXEC;
                  end
               end else if (!du_stall_i) begin     // Issue only when not stalled
                  iwb_stb_q <= 1'b1;
               end
            end
            bus_pkg::ST_EXEC: begin
               if (op == isa_pkg::OP_HALT) begin
                  state_q <= bus_pkg::ST_HALT;
               end else if (is_mem) begin
                  dwb_stb_q <= 1'b1;
                  dwb_we_q  <= (op == isa_pkg::OP_SW);
                  state_q   <= bus_pkg::ST_DATA;
               end else begin
                  pc_q    <= pc_next;
                  state_q <= bus_pkg::ST_FETCH;
               end
            end
            bus_pkg::ST_DATA: begin
               if (dwb_done) begin
                  dwb_stb_q <= 1'b0;
                  dwb_we_q  <= 1'b0;
                  pc_q      <= pc_next;            // Never a branch here
                  state_q   <= bus_pkg::ST_FETCH;
               end
            end
            default: state_q <= bus_pkg::ST_HALT;  // Stays until reset
         endcase
      end
   end

   // Instruction register and data bus payload
   always_ff @(posedge clk_i) begin
      if (fetch_done) begin
         ir_q <= iwbm_dat_i;
      end
      if ((state_q == bus_pkg::ST_EXEC) && is_mem) begin
         dwb_adr_q <= rs_val + imm_sext;           // Byte address
         dwb_dat_q <= rd_val;                      // Store data from rd
      end
   end

   // Instruction bus
   assign iwbm_cyc_o = iwb_stb_q;
   assign iwbm_stb_o = iwb_stb_q;
   assign iwbm_adr_o = pc_q;
   assign iwbm_cti_o = bus_pkg::CTI_CLASSIC;

   // Data bus
   assign dwbm_cyc_o = dwb_stb_q;
   assign dwbm_stb_o = dwb_stb_q;
   assign dwbm_we_o  = dwb_we_q;
   assign dwbm_adr_o = dwb_adr_q;
   assign dwbm_dat_o = dwb_dat_q;
   assign dwbm_cti_o = bus_pkg::CTI_CLASSIC;

   assign du_halt_o = (state_q == bus_pkg::ST_HALT);

   // Trace of the retiring instruction
   assign traceport_exec_valid_o  = retire;
   assign traceport_exec_pc_o     = pc_q;
   assign traceport_exec_insn_o   = ir_q;
   assign traceport_exec_wben_o   = wben;
   assign traceport_exec_wbreg_o  = ir_q.rd;
   assign traceport_exec_wbdata_o = wb_val;

endmodule

//--- source/cpu_module.sv
`timescale 1ns/100ps
`include "tile_defs.svh"

module cpu_module (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      dbg_stall_i,   // External stall
   output logic                      dbg_bp_o,      // High once the core halts

   // Instruction Wishbone
   input  logic                      iwb_ack_i,
   input  isa_pkg::word_t            iwb_dat_i,
   output logic                      iwb_cyc_o,
   output logic                      iwb_stb_o,
   output isa_pkg::word_t            iwb_adr_o,

   // Data Wishbone
   output logic                      dwb_cyc_o,
   output logic                      dwb_stb_o,
   output logic                      dwb_we_o,
   output isa_pkg::word_t            dwb_adr_o,
   output isa_pkg::word_t            dwb_dat_o,
   input  logic                      dwb_ack_i,
   input  isa_pkg::word_t            dwb_dat_i,

   output logic [`TRACE_WIDTH-1:0]   trace_o
);

   logic               traceport_exec_valid;
   isa_pkg::word_t     traceport_exec_pc;
   isa_pkg::word_t     traceport_exec_insn;
   logic               traceport_exec_wben;
   isa_pkg::reg_idx_t  traceport_exec_wbreg;
   isa_pkg::word_t     traceport_exec_wbdata;

   // Flat trace vector
   assign trace_o[`TRACE_VALID_BIT]                     = traceport_exec_valid;
   assign trace_o[`TRACE_PC_MSB:`TRACE_PC_LSB]          = traceport_exec_pc;
   assign trace_o[`TRACE_INSN_MSB:`TRACE_INSN_LSB]      = traceport_exec_insn;
   assign trace_o[`TRACE_WBEN_BIT]                      = traceport_exec_wben;
   assign trace_o[`TRACE_WBREG_MSB:`TRACE_WBREG_LSB]    = traceport_exec_wbreg;
   assign trace_o[`TRACE_WBDATA_MSB:`TRACE_WBDATA_LSB]  = traceport_exec_wbdata;

   cpu_core u_cpu_core (
      .clk_i                   (clk_i),
      .arst_n_i                (arst_n_i),
      .iwbm_cyc_o              (iwb_cyc_o),
      .iwbm_stb_o              (iwb_stb_o),
      .iwbm_adr_o              (iwb_adr_o),
      .iwbm_cti_o              (),
      .iwbm_ack_i              (iwb_ack_i),
      .iwbm_dat_i              (iwb_dat_i),
      .dwbm_cyc_o              (dwb_cyc_o),
      .dwbm_stb_o              (dwb_stb_o),
      .dwbm_we_o               (dwb_we_o),
      .dwbm_adr_o              (dwb_adr_o),
      .dwbm_dat_o              (dwb_dat_o),
      .dwbm_cti_o              (),
      .dwbm_ack_i              (dwb_ack_i),
      .dwbm_dat_i              (dwb_dat_i),
      .du_stall_i              (dbg_stall_i),
      .du_halt_o               (dbg_bp_o),
      .traceport_exec_valid_o  (traceport_exec_valid),
      .traceport_exec_pc_o     (traceport_exec_pc),
      .traceport_exec_insn_o   (traceport_exec_insn),
      .traceport_exec_wben_o   (traceport_exec_wben),
      .traceport_exec_wbreg_o  (traceport_exec_wbreg),
      .traceport_exec_wbdata_o (traceport_exec_wbdata)
   );

endmodule

//--- source/local_ram.sv
`timescale 1ns/100ps
`include "tile_defs.svh"

module local_ram #(
   parameter int ADDR_WIDTH = `LOCAL_RAM_AW        // Word address bits
) (
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic             wb_cyc_i,
   input  logic             wb_stb_i,
   input  logic             wb_we_i,
   input  isa_pkg::word_t   wb_adr_i,             // Byte address
   input  isa_pkg::word_t   wb_dat_i,
   output logic             wb_ack_o,
   output isa_pkg::word_t   wb_dat_o
);

   localparam int DEPTH = 2 ** ADDR_WIDTH;

   isa_pkg::word_t          mem_q [DEPTH];
   isa_pkg::word_t          rd_dat_q;
   logic                    ack_q;
   logic                    req;
   logic [ADDR_WIDTH-1:0]   word_idx;

   assign req      = wb_cyc_i && wb_stb_i;
   assign word_idx = wb_adr_i[ADDR_WIDTH+1:2];   // Wraps modulo DEPTH

   // Single ack pulse, one cycle after the strobe is seen
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req && !ack_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req && !ack_q) begin
         rd_dat_q <= mem_q[word_idx];              // Presented with the ack
      end
      if (req && ack_q && wb_we_i) begin
         mem_q[word_idx] <= wb_dat_i;              // Write lands on ack cycle
      end
   end

   assign wb_ack_o = ack_q;
   assign wb_dat_o = rd_dat_q;

endmodule

//--- source/compute_tile.sv
`timescale 1ns/100ps
`include "tile_defs.svh"

module compute_tile (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      dbg_stall_i,

   // Instruction Wishbone, served outside the tile
   input  logic                      iwb_ack_i,
   input  isa_pkg::word_t            iwb_dat_i,
   output logic                      iwb_cyc_o,
   output logic                      iwb_stb_o,
   output isa_pkg::word_t            iwb_adr_o,

   output logic                      dbg_bp_o,
   output logic [`TRACE_WIDTH-1:0]   trace_o
);

   // Core data master to local RAM
   logic             dwb_cyc;
   logic             dwb_stb;
   logic             dwb_we;
   isa_pkg::word_t   dwb_adr;
   isa_pkg::word_t   dwb_wdat;
   logic             dwb_ack;
   isa_pkg::word_t   dwb_rdat;

   cpu_module u_cpu_module (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .dbg_stall_i  (dbg_stall_i),
      .dbg_bp_o     (dbg_bp_o),
      .iwb_ack_i    (iwb_ack_i),
      .iwb_dat_i    (iwb_dat_i),
      .iwb_cyc_o    (iwb_cyc_o),
      .iwb_stb_o    (iwb_stb_o),
      .iwb_adr_o    (iwb_adr_o),
      .dwb_cyc_o    (dwb_cyc),
      .dwb_stb_o    (dwb_stb),
      .dwb_we_o     (dwb_we),
      .dwb_adr_o    (dwb_adr),
      .dwb_dat_o    (dwb_wdat),
      .dwb_ack_i    (dwb_ack),
      .dwb_dat_i    (dwb_rdat),
      .trace_o      (trace_o)
   );

   local_ram #(
      .ADDR_WIDTH   (`LOCAL_RAM_AW)
   ) u_local_ram (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .wb_cyc_i     (dwb_cyc),
      .wb_stb_i     (dwb_stb),
      .wb_we_i      (dwb_we),
      .wb_adr_i     (dwb_adr),
      .wb_dat_i     (dwb_wdat),
      .wb_ack_o     (dwb_ack),
      .wb_dat_o     (dwb_rdat)
   );

endmodule

//--- test/compute_tile_asserts.sv
`timescale 1ns/100ps
`include "tile_defs.svh"

module compute_tile_asserts (
   input  logic   clk_i,
   input  logic   arst_n_i,
   input  logic   dbg_stall_i,
   input  logic   dbg_bp_i,
   input  logic   iwb_cyc_i,
   input  logic   iwb_stb_i,
   input  logic   iwb_ack_i,
   input  logic   dwb_cyc_i,
   input  logic   dwb_stb_i,
   input  logic   dwb_ack_i,
   input  logic   trace_valid_i
);

   // Classic Wishbone framing on both masters
   a_iwb_stb_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      iwb_stb_i |-> iwb_cyc_i) else $error("iwb strobe high without cycle");
   a_dwb_stb_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      dwb_stb_i |-> dwb_cyc_i) else $error("dwb strobe high without cycle");

   // Strobe may only drop after the slave acks
   a_iwb_stb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      iwb_stb_i && !iwb_ack_i |=> iwb_stb_i) else $error("iwb strobe dropped before ack");
   a_dwb_stb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      dwb_stb_i && !dwb_ack_i |=> dwb_stb_i) else $error("dwb strobe dropped before ack");

   // One retire per pulse, never back to back
   a_trace_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      trace_valid_i |=> !trace_valid_i) else $error("trace valid high two cycles in a row");

   // Stall seen at the issuing edge blocks a new fetch
   a_no_fetch_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(iwb_stb_i) |-> !$past(dbg_stall_i)) else $error("fetch issued during stall");

   a_halt_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      dbg_bp_i |=> dbg_bp_i) else $error("breakpoint dropped while halted");

endmodule

bind cpu_module compute_tile_asserts u_compute_tile_asserts (
   .clk_i          (clk_i),
   .arst_n_i       (arst_n_i),
   .dbg_stall_i    (dbg_stall_i),
   .dbg_bp_i       (dbg_bp_o),
   .iwb_cyc_i      (iwb_cyc_o),
   .iwb_stb_i      (iwb_stb_o),
   .iwb_ack_i      (iwb_ack_i),
   .dwb_cyc_i      (dwb_cyc_o),
   .dwb_stb_i      (dwb_stb_o),
   .dwb_ack_i      (dwb_ack_i),
   .trace_valid_i  (trace_o[`TRACE_VALID_BIT])
);

//--- test/tb_compute_tile.sv
`timescale 1ns/100ps
`include "tile_defs.svh"

module tb_compute_tile;

   localparam int NUM_TESTS       = 7;
   localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS;

   logic                      clk_i = 1'b0;
   logic                      arst_n_i;
   logic                      dbg_stall_i;
   logic                      iwb_ack_i;
   isa_pkg::word_t            iwb_dat_i;
   logic                      iwb_cyc_o;
   logic                      iwb_stb_o;
   isa_pkg::word_t            iwb_adr_o;
   logic                      dbg_bp_o;
   logic [`TRACE_WIDTH-1:0]   trace_o;

   string              test_name [NUM_TESTS];
   isa_pkg::word_t     prog_tab [NUM_TESTS][8];    // Instruction memory per entry
   logic               ack_rand_tab [NUM_TESTS];
   logic               stall_tab [NUM_TESTS];
   isa_pkg::word_t     base_prog [3][8];

   isa_pkg::word_t     exp_pc[$];                  // Model retire stream
   isa_pkg::word_t     exp_insn[$];
   logic               exp_wben[$];
   isa_pkg::reg_idx_t  exp_wbreg[$];
   isa_pkg::word_t     exp_wbdata[$];

   int     delay_tab [64];                         // Pre-drawn ack delays
   int     window_tab [64];                        // Pre-drawn stall windows
   int     cur_test;
   int     ret_idx;
   logic   running;
   logic   ack_rand;
   logic   stall_mode;
   logic   stb_prev;
   int     wait_left;
   int     stall_left;
   int     draw_idx;
   int     window_idx;

   always #20 clk_i = ~clk_i;                      // 40 ns period

   compute_tile u_compute_tile (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .dbg_stall_i  (dbg_stall_i),
      .iwb_ack_i    (iwb_ack_i),
      .iwb_dat_i    (iwb_dat_i),
      .iwb_cyc_o    (iwb_cyc_o),
      .iwb_stb_o    (iwb_stb_o),
      .iwb_adr_o    (iwb_adr_o),
      .dbg_bp_o     (dbg_bp_o),
      .trace_o      (trace_o)
   );

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input isa_pkg::word_t exp_v,
                             input isa_pkg::word_t act_v);
      if (act_v !== exp_v) begin
         stop_run($sformatf("FAILED %s: expected %h, actual %h", name, exp_v, act_v));
      end
   endtask

   task automatic check_reg(input string name, input isa_pkg::reg_idx_t exp_v,
                            input isa_pkg::reg_idx_t act_v);
      if (act_v !== exp_v) begin
         stop_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp_v, act_v));
      end
   endtask

   task automatic check_bit(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         stop_run($sformatf("FAILED %s: expected %b, actual %b", name, exp_v, act_v));
      end
   endtask

   function automatic isa_pkg::word_t encode_insn(input isa_pkg::opcode_e op,
         input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs, input logic [15:0] imm);
      return {op, rd, rs, 8'h00, imm};
   endfunction

   task automatic build_programs();
      // Arithmetic with negative immediates
      base_prog[0] = '{encode_insn(isa_pkg::OP_LI,   2'd0, 2'd0, 16'd5),
                       encode_insn(isa_pkg::OP_LI,   2'd1, 2'd0, 16'hFFFD),
                       encode_insn(isa_pkg::OP_ADDI, 2'd0, 2'd0, 16'hFFF9),
                       encode_insn(isa_pkg::OP_ADD,  2'd1, 2'd0, 16'd0),
                       encode_insn(isa_pkg::OP_ADD,  2'd2, 2'd1, 16'd0),
                       encode_insn(isa_pkg::OP_ADDI, 2'd3, 2'd0, 16'h7FFF),
                       encode_insn(isa_pkg::OP_NOP,  2'd0, 2'd0, 16'd0),
                       encode_insn(isa_pkg::OP_HALT, 2'd0, 2'd0, 16'd0)};
      // Store and load with the second pair aliased past the RAM depth
      base_prog[1] = '{encode_insn(isa_pkg::OP_LI,   2'd0, 2'd0, 16'h1234),
                       encode_insn(isa_pkg::OP_LI,   2'd1, 2'd0, 16'd8),
                       encode_insn(isa_pkg::OP_SW,   2'd0, 2'd1, 16'd4),
                       encode_insn(isa_pkg::OP_LW,   2'd2, 2'd1, 16'h0104),
                       encode_insn(isa_pkg::OP_ADDI, 2'd2, 2'd0, 16'd1),
                       encode_insn(isa_pkg::OP_SW,   2'd2, 2'd1, 16'hFFF8),
                       encode_insn(isa_pkg::OP_LW,   2'd3, 2'd3, 16'h0100),
                       encode_insn(isa_pkg::OP_HALT, 2'd0, 2'd0, 16'd0)};
      // Countdown loop with an unused opcode in word 5
      base_prog[2] = '{encode_insn(isa_pkg::OP_LI,   2'd0, 2'd0, 16'd3),
                       encode_insn(isa_pkg::OP_LI,   2'd1, 2'd0, 16'd0),
                       encode_insn(isa_pkg::OP_ADDI, 2'd1, 2'd0, 16'd2),
                       encode_insn(isa_pkg::OP_ADDI, 2'd0, 2'd0, 16'hFFFF),
                       encode_insn(isa_pkg::OP_BNZ,  2'd0, 2'd0, 16'd2),
                       32'hF000_0000,
                       encode_insn(isa_pkg::OP_ADD,  2'd2, 2'd1, 16'd0),
                       encode_insn(isa_pkg::OP_HALT, 2'd0, 2'd0, 16'd0)};
   endtask

   task automatic add_entry(input int t, input string name, input int prog_id,
                            input logic rand_ack, input logic stall);
      test_name[t]    = name;
      prog_tab[t]     = base_prog[prog_id];
      ack_rand_tab[t] = rand_ack;
      stall_tab[t]    = stall;
   endtask

   // ISA reference model filling the expected retire stream
   task automatic predict(input int t);
      isa_pkg::word_t     regs [4];
      isa_pkg::word_t     dmem [64];
      isa_pkg::word_t     pc;
      isa_pkg::word_t     insn;
      isa_pkg::word_t     imm_s;
      isa_pkg::word_t     addr;
      isa_pkg::word_t     val;
      isa_pkg::word_t     next_pc;
      isa_pkg::reg_idx_t  rd;
      isa_pkg::reg_idx_t  rs;
      logic [3:0]         raw;
      logic               wen;
      logic               halted;
      int                 step;
      exp_pc.delete();
      exp_insn.delete();
      exp_wben.delete();
      exp_wbreg.delete();
      exp_wbdata.delete();
      regs   = '{default: '0};
      pc     = '0;
      halted = 1'b0;
      for (step = 0; step < 100 && !halted; step++) begin
         insn    = prog_tab[t][pc[4:2]];
         raw     = insn[31:28];
         rd      = insn[27:26];
         rs      = insn[25:24];
         imm_s   = {{16{insn[15]}}, insn[15:0]};
         wen     = 1'b0;
         val     = '0;
         next_pc = pc + 32'd4;
         case (raw)
            isa_pkg::OP_LI: begin
               wen = 1'b1;
               val = imm_s;
            end
            isa_pkg::OP_ADDI: begin
               wen = 1'b1;
               val = regs[rd] + imm_s;
            end
            isa_pkg::OP_ADD: begin
               wen = 1'b1;
               val = regs[rd] + regs[rs];
            end
            isa_pkg::OP_LW: begin
               addr = regs[rs] + imm_s;
               wen  = 1'b1;
               val  = dmem[addr[7:2]];                 // 64-word RAM wraps
            end
            isa_pkg::OP_SW: begin
               addr             = regs[rs] + imm_s;
               dmem[addr[7:2]]  = regs[rd];
            end
            isa_pkg::OP_BNZ: begin
               if (regs[rd] != '0) next_pc = {14'b0, insn[15:0], 2'b00};
            end
            isa_pkg::OP_HALT: halted = 1'b1;
            default: ;                                 // NOP and codes 8 to 15
         endcase
         if (wen) regs[rd] = val;
         exp_pc.push_back(pc);
         exp_insn.push_back(insn);
         exp_wben.push_back(wen);
         exp_wbreg.push_back(rd);
         exp_wbdata.push_back(val);
         pc = next_pc;
      end
   endtask

   // Instruction slave and stall source for one falling edge
   task automatic serve_bus();
      if (!arst_n_i) begin
         iwb_ack_i   = 1'b0;
         dbg_stall_i = 1'b0;
         stb_prev    = 1'b0;
         wait_left   = 0;
         stall_left  = 0;
      end else begin
         if (iwb_stb_o && !stb_prev && dbg_stall_i) begin
            stop_run($sformatf("%s: a fetch started while stall was high",
                               test_name[cur_test]));
         end
         stb_prev = iwb_stb_o;
         if (iwb_ack_i) begin
            iwb_ack_i = 1'b0;                          // Single-cycle ack
         end else if (iwb_stb_o) begin
            if (wait_left == 0) begin
               iwb_ack_i = 1'b1;
               iwb_dat_i = prog_tab[cur_test][iwb_adr_o[4:2]];
               wait_left = ack_rand ? delay_tab[draw_idx % 64] : 0;
               draw_idx++;
            end else begin
               wait_left--;
            end
         end
         if (!stall_mode) begin
            dbg_stall_i = 1'b0;
         end else if (stall_left == 0) begin
            dbg_stall_i = !dbg_stall_i;                // Next window
            stall_left  = window_tab[window_idx % 64];
            window_idx++;
         end else begin
            stall_left--;
         end
      end
   endtask

   task automatic next_cycle();
      @(negedge clk_i);
      serve_bus();
   endtask

   // Trace monitor sees the fields before the edge updates them
   always @(posedge clk_i) begin : monitor_trace
      string tag;
      if (running && trace_o[`TRACE_VALID_BIT]) begin
         tag = $sformatf("%s retire %0d", test_name[cur_test], ret_idx);
         if (ret_idx >= exp_pc.size()) begin
            stop_run($sformatf("%s: DUT retired more instructions than the model", tag));
         end else begin
            check_word({tag, " pc"}, exp_pc[ret_idx], trace_o[`TRACE_PC_MSB:`TRACE_PC_LSB]);
            check_word({tag, " insn"}, exp_insn[ret_idx],
                       trace_o[`TRACE_INSN_MSB:`TRACE_INSN_LSB]);
            check_bit({tag, " wben"}, exp_wben[ret_idx], trace_o[`TRACE_WBEN_BIT]);
            if (exp_wben[ret_idx]) begin
               check_reg({tag, " wbreg"}, exp_wbreg[ret_idx],
                         trace_o[`TRACE_WBREG_MSB:`TRACE_WBREG_LSB]);
               check_word({tag, " wbdata"}, exp_wbdata[ret_idx],
                          trace_o[`TRACE_WBDATA_MSB:`TRACE_WBDATA_LSB]);
            end
            ret_idx++;
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      stop_run("Timeout: the DUT did not finish all programs in the allowed cycles");
   end

   initial begin : main
      arst_n_i    = 1'b0;
      dbg_stall_i = 1'b0;
      iwb_ack_i   = 1'b0;
      iwb_dat_i   = '0;
      running     = 1'b0;
      ack_rand    = 1'b0;
      stall_mode  = 1'b0;
      cur_test    = 0;
      ret_idx     = 0;
      draw_idx    = 0;
      window_idx  = 0;
      void'($urandom(88010));
      for (int i = 0; i < 64; i++) begin
         delay_tab[i]  = int'($urandom_range(3));      // 0 to 3 cycles
         window_tab[i] = int'($urandom_range(5, 1));
      end
      build_programs();
      add_entry(0, "arith",       0, 1'b0, 1'b0);
      add_entry(1, "mem_wrap",    1, 1'b0, 1'b0);
      add_entry(2, "bnz_loop",    2, 1'b0, 1'b0);
      add_entry(3, "arith_delay", 0, 1'b1, 1'b0);
      add_entry(4, "bnz_delay",   2, 1'b1, 1'b0);
      add_entry(5, "mem_stall",   1, 1'b1, 1'b1);
      add_entry(6, "bnz_stall",   2, 1'b0, 1'b1);
      for (int t = 0; t < NUM_TESTS; t++) begin
         next_cycle();
         arst_n_i   = 1'b0;
         running    = 1'b0;
         cur_test   = t;
         ack_rand   = ack_rand_tab[t];
         stall_mode = stall_tab[t];
         ret_idx    = 0;
         predict(t);
         repeat (4) next_cycle();                      // Reset held 4 cycles
         check_bit({test_name[t], " reset cyc"}, 1'b0, iwb_cyc_o);
         check_bit({test_name[t], " reset stb"}, 1'b0, iwb_stb_o);
         check_bit({test_name[t], " reset bp"}, 1'b0, dbg_bp_o);
         check_bit({test_name[t], " reset valid"}, 1'b0, trace_o[`TRACE_VALID_BIT]);
         arst_n_i = 1'b1;
         running  = 1'b1;
         while (!iwb_stb_o) next_cycle();
         check_word({test_name[t], " first fetch"}, 32'd0, iwb_adr_o);
         while (!dbg_bp_o) next_cycle();
         check_word({test_name[t], " retired count"}, isa_pkg::word_t'(exp_pc.size()),
                    isa_pkg::word_t'(ret_idx));
         check_bit({test_name[t], " halted cyc"}, 1'b0, iwb_cyc_o);
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

//--- compute_tile.f
+incdir+source
source/isa_pkg.sv
source/bus_pkg.sv
source/cpu_core.sv
source/cpu_module.sv
source/local_ram.sv
source/compute_tile.sv
test/compute_tile_asserts.sv
test/tb_compute_tile.sv

//--- run.sh
#!/bin/sh
# Build and run the compute tile testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_compute_tile -f compute_tile.f -o sim_tb

# The simulator exits non-zero on $fatal, the log decides the verdict
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
   echo "No pass line in sim.log"
   exit 1
fi
exit 0
